// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uno_referee -f uno_referee.f -o tb_uno_referee
out=$(./obj_dir/tb_uno_referee)
echo "$out"
if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1

// File: tb_uno_referee.sv
module tb_uno_referee;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         TIMEOUT     = 2000;  // cycles per wait
    localparam int         DEAL_CARDS  = 7;
    localparam logic [3:0] VAL_SKIP    = 4'd10;
    localparam logic [3:0] VAL_REVERSE = 4'd11;
    localparam logic [3:0] VAL_DRAW2   = 4'd12;
    localparam logic [3:0] VAL_WILD    = 4'd13;
    localparam logic [3:0] VAL_WILD4   = 4'd14;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        start;
    logic        play_valid;
    logic [5:0]  play_card;       // colour in [5:4], value in [3:0]
    logic        draw_ready = 1'b0;
    logic        play_ready;
    logic        draw_valid;
    logic [1:0]  draw_seat;
    logic        turn_valid;
    logic [1:0]  turn_seat;
    logic [5:0]  top_card;
    logic        top_valid;
    logic        reversed;
    logic        play_illegal;

    logic [15:0] lfsr = 16'd25981;
    logic [1:0]  draw_log[$];     // seat of every accepted draw
    int          checks;
    int          errors;
    int          tests;
    bit          hung;

    logic [1:0]  m_seat;          // reference table state
    logic        m_rev;
    logic [5:0]  m_top;
    logic        m_top_valid;

    uno_referee dut_i (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_start        (start),
        .i_play_valid   (play_valid),
        .o_play_ready   (play_ready),
        .i_play_card    (play_card),
        .o_draw_valid   (draw_valid),
        .o_draw_seat    (draw_seat),
        .i_draw_ready   (draw_ready),
        .o_turn_valid   (turn_valid),
        .o_turn_seat    (turn_seat),
        .o_top_card     (top_card),
        .o_top_valid    (top_valid),
        .o_reversed     (reversed),
        .o_play_illegal (play_illegal)
    );

    always #20 clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // deck stalls at random
    always @(posedge clk) begin
        if (draw_valid && draw_ready) begin
            draw_log.push_back(draw_seat);
        end
        lfsr = lfsr_step(lfsr);
        draw_ready <= lfsr[0];
    end

    task automatic compare_value(input string what, input int got, input int exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%s: %0d errors", name, errors - errs_before);
    endtask

    task automatic wait_turn(input string what);
        int n;
        if (hung) return;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (turn_valid && play_ready) break;
        end
        if (n == TIMEOUT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: no turn was offered (%s)", $time, what);
        end
    endtask

    task automatic play_turn(input logic [1:0] colour, input logic [3:0] value);
        logic       legal;
        logic       nrev;
        logic [1:0] step;
        logic [1:0] nseat;
        int         exp_draws;
        int         n;
        bit         seen_low;
        bit         got_illegal;
        legal = !m_top_valid || colour == m_top[5:4] || value == m_top[3:0]
                || value == VAL_WILD || value == VAL_WILD4;
        nrev  = m_rev ^ (value == VAL_REVERSE);
        step  = (value == VAL_SKIP) ? 2'd2 : 2'd1;
        nseat = nrev ? m_seat - step : m_seat + step;  // wraps over four seats
        exp_draws = !legal ? 0 : (value == VAL_DRAW2) ? 2 : (value == VAL_WILD4) ? 4 : 0;
        wait_turn("before play");
        if (hung) return;
        draw_log.delete();
        play_valid <= 1'b1;
        play_card  <= {colour, value};
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (play_ready) break;
        end
        play_valid <= 1'b0;
        if (n == TIMEOUT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: the card was never accepted", $time);
            return;
        end
        seen_low    = 1'b0;
        got_illegal = 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk);
            if (play_illegal) begin
                got_illegal = 1'b1;
                break;
            end
            if (!turn_valid) seen_low = 1'b1;
            else if (seen_low) break;   // next turn offered
        end
        if (n == TIMEOUT) begin
            hung = 1'b1;
            $display("timeout at %0t ns: no response to a played card", $time);
            return;
        end
        compare_value("illegal flag", int'(got_illegal), int'(!legal));
        if (legal) begin
            m_seat      = nseat;
            m_rev       = nrev;
            m_top       = {colour, value};
            m_top_valid = 1'b1;
        end
        compare_value("turn seat", int'(turn_seat), int'(m_seat));
        compare_value("top valid", int'(top_valid), int'(m_top_valid));
        compare_value("reversed", int'(reversed), int'(m_rev));
        if (m_top_valid) compare_value("top card", int'(top_card), int'(m_top));
        compare_value("draw count", draw_log.size(), exp_draws);
        foreach (draw_log[k]) compare_value("draw seat", int'(draw_log[k]), int'(nseat));
    endtask

    task automatic deal_cards;
        int errs;
        errs = errors;
        draw_log.delete();
        @(posedge clk);
        compare_value("play ready after reset", int'(play_ready), 1);
        compare_value("turn valid after reset", int'(turn_valid), 0);
        compare_value("draw valid after reset", int'(draw_valid), 0);
        compare_value("illegal flag after reset", int'(play_illegal), 0);
        compare_value("top valid after reset", int'(top_valid), 0);
        compare_value("reversed after reset", int'(reversed), 0);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_turn("end of deal");
        if (!hung) begin
            compare_value("deal draws", draw_log.size(), 4 * DEAL_CARDS);
            foreach (draw_log[k]) compare_value("deal seat", int'(draw_log[k]), k / DEAL_CARDS);
            compare_value("first turn seat", int'(turn_seat), 0);
            compare_value("top valid after deal", int'(top_valid), 0);
        end
        m_seat      = 2'd0;
        m_rev       = 1'b0;
        m_top       = '0;
        m_top_valid = 1'b0;
        report_test("deal", errs);
    endtask

    task automatic number_plays;
        int errs;
        errs = errors;
        play_turn(2'd0, 4'd5);          // empty pile takes anything
        play_turn(2'd0, 4'd7);
        play_turn(2'd2, 4'd7);
        play_turn(2'd1, 4'd3);          // neither colour nor value
        play_turn(2'd2, 4'd3);
        report_test("numbers", errs);
    endtask

    task automatic skip_and_reverse;
        int errs;
        errs = errors;
        play_turn(2'd2, VAL_SKIP);
        play_turn(2'd2, VAL_REVERSE);
        play_turn(2'd2, VAL_REVERSE);   // back to clockwise
        report_test("skip and reverse", errs);
    endtask

    task automatic penalty_draws;
        int errs;
        errs = errors;
        play_turn(2'd2, VAL_DRAW2);
        play_turn(2'd3, VAL_WILD4);
        play_turn(2'd3, VAL_REVERSE);
        play_turn(2'd3, VAL_DRAW2);     // victim counter-clockwise
        report_test("penalty draws", errs);
    endtask

    task automatic wild_colour;
        int errs;
        errs = errors;
        play_turn(2'd3, 4'd8);
        play_turn(2'd1, VAL_WILD);
        play_turn(2'd3, 4'd6);          // old pile colour only
        play_turn(2'd1, 4'd6);
        report_test("wild colour", errs);
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        play_valid = 1'b0;
        play_card  = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        deal_cards();
        number_plays();
        skip_and_reverse();
        penalty_draws();
        wild_colour();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (hung || errors != 0) begin
            $display("Simulation failed");
        end else begin
            $display("Simulation passed");
        end
        $finish;
    end

endmodule

// File: uno_action_if.sv
interface uno_action_if;

    logic              valid;
    logic              ready;
    uno_pkg::card_t    card;
    uno_pkg::action_e  action;  // decoded from card.value

    modport source (
        output valid,
        output card,
        output action,
        input  ready
    );

    modport sink (
        input  valid,
        input  card,
        input  action,
        output ready
    );

endinterface

// File: uno_defs.svh
`ifndef UNO_DEFS_SVH
`define UNO_DEFS_SVH

`define UNO_SEATS       4
`define UNO_DEAL_CARDS  7      // per seat at start
`define UNO_CARD_W      6      // colour in [5:4], value in [3:0]
`define UNO_COUNT_W     3

`define UNO_VAL_SKIP    4'd10
`define UNO_VAL_REVERSE 4'd11
`define UNO_VAL_DRAW2   4'd12
`define UNO_VAL_WILD    4'd13
`define UNO_VAL_WILD4   4'd14

`define UNO_DRAW2_COUNT 2
`define UNO_DRAW4_COUNT 4

`endif

// File: uno_draw_if.sv
interface uno_draw_if;

    logic                req_valid;  // single-cycle pulse
    uno_pkg::seat_t      seat;
    uno_pkg::draw_cnt_t  count;
    logic                busy;

    modport request (
        output req_valid,
        output seat,
        output count,
        input  busy
    );

    modport issuer (
        input  req_valid,
        input  seat,
        input  count,
        output busy
    );

endinterface

// File: uno_draw_issuer.sv
module uno_draw_issuer
    import uno_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    uno_draw_if.issuer   draw,
    output logic         o_draw_valid,
    output seat_t        o_draw_seat,
    input  logic         i_draw_ready
);

    draw_cnt_t left_r;
    seat_t     seat_r;
    logic      pending;
    logic      push_ready;

    assign pending = left_r != '0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            left_r <= '0;
        end else if (draw.req_valid) begin
            left_r <= draw.count;
        end else if (pending && push_ready) begin
            left_r <= left_r - draw_cnt_t'(1);  // one card per cycle
        end
    end

    always_ff @(posedge i_clk) begin
        if (draw.req_valid) begin
            seat_r <= draw.seat;
        end
    end

    uno_hold_reg #(
        .T (seat_t)
    ) seat_hold_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (pending),
        .o_ready (push_ready),
        .i_data  (seat_r),
        .o_valid (o_draw_valid),
        .i_ready (i_draw_ready),
        .o_data  (o_draw_seat)
    );

    assign draw.busy = pending || o_draw_valid;  // low once last draw is taken

endmodule

// File: uno_hold_reg.sv
module uno_hold_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic full_r;
    T     data_r;

    assign o_ready = !full_r || i_ready;  // refill while draining
    assign o_valid = full_r;
    assign o_data  = data_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            full_r <= 1'b0;
        end else if (o_ready) begin
            full_r <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            data_r <= i_data;
        end
    end

    a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// File: uno_pkg.sv
`include "uno_defs.svh"

package uno_pkg;

    typedef struct packed {
        logic [`UNO_CARD_W-5:0] colour;  // chosen colour for wilds
        logic [3:0]             value;
    } card_t;

    typedef logic [$clog2(`UNO_SEATS)-1:0] seat_t;

    typedef enum logic [2:0] {
        ACT_NUMBER,
        ACT_SKIP,
        ACT_REVERSE,
        ACT_DRAW2,
        ACT_WILD,
        ACT_WILD4
    } action_e;

    typedef logic [`UNO_COUNT_W-1:0] draw_cnt_t;

endpackage

// File: uno_play_intake.sv
`include "uno_defs.svh"

module uno_play_intake
    import uno_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_play_valid,
    output logic                o_play_ready,
    input  card_t               i_play_card,
    uno_action_if.source        act
);

    uno_hold_reg #(
        .T (card_t)
    ) card_hold_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_play_valid),
        .o_ready (o_play_ready),
        .i_data  (i_play_card),
        .o_valid (act.valid),
        .i_ready (act.ready),
        .o_data  (act.card)
    );

    // values 0..9 are plain numbers
    always_comb begin
        case (act.card.value)
            `UNO_VAL_SKIP:    act.action = ACT_SKIP;
            `UNO_VAL_REVERSE: act.action = ACT_REVERSE;
            `UNO_VAL_DRAW2:   act.action = ACT_DRAW2;
            `UNO_VAL_WILD:    act.action = ACT_WILD;
            `UNO_VAL_WILD4:   act.action = ACT_WILD4;
            default:          act.action = ACT_NUMBER;
        endcase
    end

endmodule

// File: uno_referee.f
+incdir+.
uno_pkg.sv
uno_action_if.sv
uno_draw_if.sv
uno_hold_reg.sv
uno_play_intake.sv
uno_turn_seq.sv
uno_draw_issuer.sv
uno_referee.sv
tb_uno_referee.sv

// File: uno_referee.sv
module uno_referee
    import uno_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_start,
    input  logic  i_play_valid,
    output logic  o_play_ready,
    input  card_t i_play_card,
    output logic  o_draw_valid,
    output seat_t o_draw_seat,
    input  logic  i_draw_ready,
    output logic  o_turn_valid,
    output seat_t o_turn_seat,
    output card_t o_top_card,
    output logic  o_top_valid,
    output logic  o_reversed,
    output logic  o_play_illegal
);

    uno_action_if act_if ();
    uno_draw_if   draw_if ();

    uno_play_intake intake_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_play_valid (i_play_valid),
        .o_play_ready (o_play_ready),
        .i_play_card  (i_play_card),
        .act          (act_if.source)
    );

    uno_turn_seq seq_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .act            (act_if.sink),
        .draw           (draw_if.request),
        .o_turn_valid   (o_turn_valid),
        .o_turn_seat    (o_turn_seat),
        .o_top_card     (o_top_card),
        .o_top_valid    (o_top_valid),
        .o_reversed     (o_reversed),
        .o_play_illegal (o_play_illegal)
    );

    uno_draw_issuer issuer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .draw         (draw_if.issuer),
        .o_draw_valid (o_draw_valid),
        .o_draw_seat  (o_draw_seat),
        .i_draw_ready (i_draw_ready)
    );

endmodule

// File: uno_turn_seq.sv
`include "uno_defs.svh"

module uno_turn_seq
    import uno_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_start,
    uno_action_if.sink   act,
    uno_draw_if.request  draw,
    output logic         o_turn_valid,
    output seat_t        o_turn_seat,
    output card_t        o_top_card,
    output logic         o_top_valid,
    output logic         o_reversed,
    output logic         o_play_illegal
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DEAL_REQ,
        S_DEAL_WAIT,
        S_PLAY,
        S_PENALTY_WAIT
    } state_e;

    state_e    state_r;
    seat_t     seat_r;
    seat_t     deal_seat_r;
    seat_t     req_seat_r;
    seat_t     step;
    seat_t     next_seat;
    draw_cnt_t req_cnt_r;
    card_t     top_r;
    logic      top_valid_r;
    logic      reversed_r;
    logic      turn_valid_r;
    logic      illegal_r;
    logic      req_r;
    logic      take;
    logic      legal;
    logic      flip;
    logic      penalty;

    assign take    = act.valid && act.ready;
    assign legal   = !top_valid_r || act.card.colour == top_r.colour
                     || act.card.value == top_r.value
                     || act.action == ACT_WILD || act.action == ACT_WILD4;
    assign penalty = act.action == ACT_DRAW2 || act.action == ACT_WILD4;
    assign flip    = reversed_r ^ (act.action == ACT_REVERSE);  // direction after this card
    assign step    = (act.action == ACT_SKIP) ? seat_t'(2) : seat_t'(1);
    assign next_seat = flip ? seat_r - step : seat_r + step;   // wraps mod 4

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r      <= S_IDLE;
            seat_r       <= '0;
            deal_seat_r  <= '0;
            top_valid_r  <= 1'b0;
            reversed_r   <= 1'b0;
            turn_valid_r <= 1'b0;
            illegal_r    <= 1'b0;
            req_r        <= 1'b0;
        end else begin
            req_r        <= 1'b0;
            illegal_r    <= 1'b0;
            turn_valid_r <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        state_r <= S_DEAL_REQ;
                    end
                end
                S_DEAL_REQ: begin
                    if (!draw.busy) begin
                        req_r   <= 1'b1;
                        state_r <= S_DEAL_WAIT;
                    end
                end
                S_DEAL_WAIT: begin
                    if (!req_r && !draw.busy) begin  // busy rises the cycle after req
                        deal_seat_r <= deal_seat_r + seat_t'(1);
                        if (deal_seat_r == seat_t'(`UNO_SEATS - 1)) begin
                            state_r      <= S_PLAY;
                            turn_valid_r <= 1'b1;
                        end else begin
                            state_r <= S_DEAL_REQ;
                        end
                    end
                end
                S_PLAY: begin
                    turn_valid_r <= !take;
                    if (take && !legal) begin
                        illegal_r <= 1'b1;
                    end else if (take) begin
                        top_valid_r <= 1'b1;
                        reversed_r  <= flip;
                        seat_r      <= next_seat;
                        if (penalty) begin
                            req_r   <= 1'b1;
                            state_r <= S_PENALTY_WAIT;
                        end
                    end
                end
                S_PENALTY_WAIT: begin
                    if (!req_r && !draw.busy) begin
                        state_r      <= S_PLAY;
                        turn_valid_r <= 1'b1;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (take && legal) begin
            top_r <= act.card;
        end
        if (state_r == S_DEAL_REQ) begin
            req_seat_r <= deal_seat_r;
            req_cnt_r  <= draw_cnt_t'(`UNO_DEAL_CARDS);
        end else if (take) begin
            req_seat_r <= next_seat;  // victim gets the turn too
            req_cnt_r  <= (act.action == ACT_WILD4) ? draw_cnt_t'(`UNO_DRAW4_COUNT)
                                                    : draw_cnt_t'(`UNO_DRAW2_COUNT);
        end
    end

    assign act.ready      = turn_valid_r;
    assign draw.req_valid = req_r;
    assign draw.seat      = req_seat_r;
    assign draw.count     = req_cnt_r;
    assign o_turn_valid   = turn_valid_r;
    assign o_turn_seat    = seat_r;
    assign o_top_card     = top_r;
    assign o_top_valid    = top_valid_r;
    assign o_reversed     = reversed_r;
    assign o_play_illegal = illegal_r;

    a_req_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        req_r |-> !draw.busy);

    a_seat_on_play: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !take |=> $stable(seat_r));

endmodule
